// File: flist.f
+incdir+verilog
verilog/lsu_pkg.sv
verilog/load_store_queue.sv
verilog/mem_access_port.sv
verilog/data_ram.sv
verilog/lsu_config_regs.sv
verilog/lsu_top.sv
testbench/lsu_tb.sv

// File: Makefile
# Verilator build and run of the load/store unit testbench

OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing -Wno-fatal -f flist.f --top-module lsu_tb -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/Vlsu_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/lsu_tb.sv
// load/store unit testbench
`timescale 1ns/10ps
`include "lsu_defs.svh"

module lsu_tb;

    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 600;
    localparam int WORST_WAIT  = 4;   // wait states used plus one

    logic clk_in = 1'b0;
    logic rst_in = 1'b1;
    logic issue_valid = 1'b0;
    lsu_pkg::mem_op_e issue_op = lsu_pkg::MEM_LOAD;
    lsu_pkg::mem_width_e issue_width = lsu_pkg::MW_WORD;
    logic [31:0] issue_imm = '0;
    logic [31:0] issue_base = '0;
    logic [31:0] issue_data = '0;
    logic issue_base_pending = 1'b0;
    logic issue_data_pending = 1'b0;
    lsu_pkg::rob_tag_t issue_base_tag = '0;
    lsu_pkg::rob_tag_t issue_data_tag = '0;
    lsu_pkg::rob_tag_t issue_dest_tag = '0;
    logic full;
    logic cdb_valid = 1'b0;
    lsu_pkg::rob_tag_t cdb_tag = '0;
    logic [31:0] cdb_value = '0;
    logic commit_valid = 1'b0;
    lsu_pkg::rob_tag_t commit_tag = '0;
    logic flush = 1'b0;
    logic result_valid;
    logic result_is_store;
    lsu_pkg::rob_tag_t result_tag;
    logic [31:0] result_value;
    logic cfg_write = 1'b0;
    logic [`CFG_ADDR_BITS-1:0] cfg_addr = '0;
    logic [31:0] cfg_wdata = '0;
    logic [31:0] cfg_rdata;

    logic [7:0]  ref_mem [4*`RAM_WORDS];
    logic        got     [16];
    logic        got_st  [16];
    logic [31:0] got_val [16];
    int          got_seq [16];
    logic        issued_st [16];  // op issued under each tag
    int          seq = 0;
    int          n_loads = 0;
    int          n_stores = 0;
    logic [31:0] lcg_state = 32'h2c48;
    int          tag_ctr = 0;

    lsu_top DUT (.*);

    always #20 clk_in = ~clk_in;

    initial begin
        #(NUM_TESTS * TEST_CYCLES * WORST_WAIT * 40);
        $display("watchdog expired, the tests did not finish in time");
        $display("STATUS: FAIL");
        $fatal(1);
    end

    // records each result under its tag
    always @(negedge clk_in) begin
        if (!rst_in && result_valid) begin
            got[result_tag]     = 1'b1;
            got_st[result_tag]  = result_is_store;
            got_val[result_tag] = result_value;
            got_seq[result_tag] = seq;
            seq = seq + 1;
            if (issued_st[result_tag]) begin
                n_stores = n_stores + 1;
            end else begin
                n_loads = n_loads + 1;
            end
        end
    end

    function automatic logic [31:0] lcg();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic lsu_pkg::rob_tag_t next_tag();
        tag_ctr = (tag_ctr + 1) % 8;  // tags 8 and up left for hand-built cases
        return lsu_pkg::rob_tag_t'(tag_ctr);
    endfunction

    // expected load value from the byte mirror
    function automatic logic [31:0] expect_load(logic [31:0] a, lsu_pkg::mem_width_e w);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = ref_mem[a[9:0]];
        b1 = ref_mem[a[9:0] + 10'd1];
        case (w)
            lsu_pkg::MW_BYTE:   return {{24{b0[7]}}, b0};
            lsu_pkg::MW_BYTE_U: return {24'h0, b0};
            lsu_pkg::MW_HALF:   return {{16{b1[7]}}, b1, b0};
            lsu_pkg::MW_HALF_U: return {16'h0, b1, b0};
            default:            return {ref_mem[a[9:0] + 10'd3], ref_mem[a[9:0] + 10'd2], b1, b0};
        endcase
    endfunction

    task automatic mirror_store(logic [31:0] a, lsu_pkg::mem_width_e w, logic [31:0] d);
        int n;
        n = (w == lsu_pkg::MW_WORD) ? 4 : (w == lsu_pkg::MW_BYTE) ? 1 : 2;
        for (int i = 0; i < n; i++) ref_mem[a[9:0] + 10'(i)] = d[8*i +: 8];
    endtask

    task automatic check_eq(string name, logic [31:0] exp, logic [31:0] act);
        assert (exp === act) else begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    // drives one entry for one cycle from a falling edge
    task automatic issue(lsu_pkg::mem_op_e op, lsu_pkg::mem_width_e w, logic [31:0] base,
                         logic [31:0] imm, logic [31:0] data, logic bp, logic dp,
                         lsu_pkg::rob_tag_t bt, lsu_pkg::rob_tag_t dt, lsu_pkg::rob_tag_t dest);
        while (full) @(negedge clk_in);
        got[dest] = 1'b0;
        issued_st[dest] = (op == lsu_pkg::MEM_STORE);
        issue_op = op;
        issue_width = w;
        issue_base = base;
        issue_imm = imm;
        issue_data = data;
        issue_base_pending = bp;
        issue_data_pending = dp;
        issue_base_tag = bt;
        issue_data_tag = dt;
        issue_dest_tag = dest;
        issue_valid = 1'b1;
        @(negedge clk_in);
        issue_valid = 1'b0;
    endtask

    task automatic wait_result(lsu_pkg::rob_tag_t tag);
        int n;
        n = 0;
        while (!got[tag] && n < 200) begin
            @(negedge clk_in);
            n++;
        end
        if (!got[tag]) begin
            $display("no result came back for tag %0d", tag);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic broadcast(lsu_pkg::rob_tag_t tag, logic [31:0] value);
        cdb_valid = 1'b1;
        cdb_tag = tag;
        cdb_value = value;
        @(negedge clk_in);
        cdb_valid = 1'b0;
    endtask

    task automatic do_store(string name, logic [31:0] a, lsu_pkg::mem_width_e w, logic [31:0] d);
        lsu_pkg::rob_tag_t t;
        t = next_tag();
        commit_valid = 1'b1;
        commit_tag = t;
        issue(lsu_pkg::MEM_STORE, w, a - 32'd16, 32'd16, d, 0, 0, 0, 0, t);
        wait_result(t);
        check_eq({name, " store flag"}, 1, got_st[t]);
        check_eq({name, " store value"}, 0, got_val[t]);
        mirror_store(a, w, d);
    endtask

    task automatic do_load(string name, logic [31:0] a, lsu_pkg::mem_width_e w);
        lsu_pkg::rob_tag_t t;
        t = next_tag();
        issue(lsu_pkg::MEM_LOAD, w, a, 32'd0, 32'd0, 0, 0, 0, 0, t);
        wait_result(t);
        check_eq({name, " load"}, expect_load(a, w), got_val[t]);
    endtask

    task automatic test_word();
        logic [31:0] a;
        for (int i = 0; i < 4; i++) begin
            a = lcg() & 32'h3fc;
            do_store("word", a, lsu_pkg::MW_WORD, lcg());
            do_load("word", a, lsu_pkg::MW_WORD);
        end
    endtask

    task automatic test_lanes();
        logic [31:0] a;
        a = lcg() & 32'h3fc;
        do_store("lanes", a, lsu_pkg::MW_WORD, lcg());
        for (int l = 0; l < 4; l++) begin
            do_store("lanes", a + l, lsu_pkg::MW_BYTE, lcg() | 32'h80 * (l % 2));
            do_load("lanes lb", a + l, lsu_pkg::MW_BYTE);
            do_load("lanes lbu", a + l, lsu_pkg::MW_BYTE_U);
        end
        for (int l = 0; l < 4; l += 2) begin
            do_store("lanes", a + l, lsu_pkg::MW_HALF, lcg());
            do_load("lanes lh", a + l, lsu_pkg::MW_HALF);
            do_load("lanes lhu", a + l, lsu_pkg::MW_HALF_U);
        end
        do_load("lanes lw", a, lsu_pkg::MW_WORD);
    endtask

    task automatic test_wakeup();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        a = lcg() & 32'h3fc;
        d = lcg();
        commit_valid = 1'b1;
        commit_tag = 4'd10;
        issue(lsu_pkg::MEM_STORE, lsu_pkg::MW_WORD, 0, 32'd4, 0, 1, 1, 4'd11, 4'd12, 4'd10);
        repeat (6) @(negedge clk_in);
        check_eq("wakeup none", 0, got[10]);
        broadcast(4'd11, a - 32'd4);
        repeat (6) @(negedge clk_in);
        check_eq("wakeup base only", 0, got[10]);
        broadcast(4'd12, d);
        wait_result(4'd10);
        mirror_store(a, lsu_pkg::MW_WORD, d);
        do_load("wakeup", a, lsu_pkg::MW_WORD);
        // store data taken from an older load result
        b = (a + 32'h40) & 32'h3fc;
        commit_tag = 4'd9;
        issue(lsu_pkg::MEM_LOAD, lsu_pkg::MW_WORD, a, 0, 0, 0, 0, 0, 0, 4'd8);
        issue(lsu_pkg::MEM_STORE, lsu_pkg::MW_WORD, b, 0, 0, 0, 1, 0, 4'd8, 4'd9);
        wait_result(4'd9);
        mirror_store(b, lsu_pkg::MW_WORD, d);
        do_load("wakeup chain", b, lsu_pkg::MW_WORD);
    endtask

    task automatic test_commit();
        logic [31:0] a;
        logic [31:0] d;
        a = lcg() & 32'h3fc;
        d = lcg();
        commit_valid = 1'b1;
        commit_tag = 4'd15;
        issue(lsu_pkg::MEM_STORE, lsu_pkg::MW_WORD, a, 0, d, 0, 0, 0, 0, 4'd8);
        issue(lsu_pkg::MEM_LOAD, lsu_pkg::MW_WORD, a, 0, 0, 0, 0, 0, 0, 4'd9);
        repeat (10) @(negedge clk_in);
        check_eq("commit store held", 0, got[8]);
        check_eq("commit load held", 0, got[9]);
        commit_tag = 4'd8;
        wait_result(4'd9);
        check_eq("commit store done", 1, got[8]);
        check_eq("commit order", 1, got_seq[8] < got_seq[9]);
        check_eq("commit load", d, got_val[9]);
        mirror_store(a, lsu_pkg::MW_WORD, d);
    endtask

    task automatic test_flush();
        for (int i = 0; i < `LSQ_DEPTH - 1; i++) begin
            issue(lsu_pkg::MEM_LOAD, lsu_pkg::MW_WORD, 0, 0, 0, 1, 0, 4'd15, 0, 4'(8 + i));
        end
        check_eq("flush full before", 1, full);
        flush = 1'b1;
        @(negedge clk_in);
        flush = 1'b0;
        broadcast(4'd15, 32'h100);
        repeat (10) @(negedge clk_in);
        for (int i = 0; i < `LSQ_DEPTH - 1; i++) begin
            check_eq("flush no result", 0, got[8 + i]);
        end
        check_eq("flush full", 0, full);
        test_word();
    endtask

    task automatic test_config();
        logic [31:0] a;
        a = lcg() & 32'h3fc;
        cfg_write = 1'b1;
        cfg_addr = `CFG_WAIT;
        cfg_wdata = 32'd3;
        @(negedge clk_in);
        cfg_write = 1'b0;
        check_eq("config wait", 3, cfg_rdata);
        do_store("config", a, lsu_pkg::MW_WORD, lcg());
        for (int i = 0; i < `LSQ_DEPTH - 1; i++) begin
            check_eq("config not full", 0, full);
            issue(lsu_pkg::MEM_LOAD, lsu_pkg::MW_WORD, 0, a, 0, 1, 0, 4'd13, 0, 4'(i));
        end
        check_eq("config full", 1, full);
        broadcast(4'd13, 32'd0);
        for (int i = 0; i < `LSQ_DEPTH - 1; i++) begin
            wait_result(4'(i));
            check_eq("config drain", expect_load(a, lsu_pkg::MW_WORD), got_val[i]);
        end
        @(negedge clk_in);
        cfg_addr = `CFG_LOADS;
        #1 check_eq("config loads", n_loads, cfg_rdata);
        cfg_addr = `CFG_STORES;
        #1 check_eq("config stores", n_stores, cfg_rdata);
    endtask

    initial begin
        for (int i = 0; i < 16; i++) begin
            got[i] = 1'b0;
            got_st[i] = 1'b0;
            got_val[i] = '0;
            got_seq[i] = 0;
            issued_st[i] = 1'b0;
        end
        repeat (3) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;
        test_word();
        test_lanes();
        test_wakeup();
        test_commit();
        test_flush();
        test_config();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: verilog/lsu_top.sv
// load/store unit top
`timescale 1ns/10ps
`include "lsu_defs.svh"

module lsu_top (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  logic                      issue_valid,
    input  lsu_pkg::mem_op_e          issue_op,
    input  lsu_pkg::mem_width_e       issue_width,
    input  logic [31:0]               issue_imm,
    input  logic [31:0]               issue_base,
    input  logic [31:0]               issue_data,
    input  logic                      issue_base_pending,
    input  logic                      issue_data_pending,
    input  lsu_pkg::rob_tag_t         issue_base_tag,
    input  lsu_pkg::rob_tag_t         issue_data_tag,
    input  lsu_pkg::rob_tag_t         issue_dest_tag,
    output logic                      full,
    input  logic                      cdb_valid,
    input  lsu_pkg::rob_tag_t         cdb_tag,
    input  logic [31:0]               cdb_value,
    input  logic                      commit_valid,
    input  lsu_pkg::rob_tag_t         commit_tag,
    input  logic                      flush,
    output logic                      result_valid,
    output logic                      result_is_store,
    output lsu_pkg::rob_tag_t         result_tag,
    output logic [31:0]               result_value,
    input  logic                      cfg_write,
    input  logic [`CFG_ADDR_BITS-1:0] cfg_addr,
    input  logic [31:0]               cfg_wdata,
    output logic [31:0]               cfg_rdata
);

    // queue to port handshake
    logic                mem_req;
    lsu_pkg::mem_op_e    mem_op;
    lsu_pkg::mem_width_e mem_width;
    logic [31:0]         mem_addr;
    logic [31:0]         mem_wdata;
    logic                mem_ack;
    logic [31:0]         mem_rdata;

    // port to RAM
    logic                  ram_en;
    logic                  ram_we;
    logic [`RAM_BITS-1:0]  ram_addr;
    logic [3:0]            ram_be;
    logic [31:0]           ram_wdata;
    logic [31:0]           ram_rdata;
    logic                  ram_ready;
    logic [`WAIT_BITS-1:0] wait_states;

    load_store_queue u_lsq (.*);

    mem_access_port u_port (.*);

    data_ram u_ram (.*);

    lsu_config_regs u_cfg (.*);

endmodule

// File: verilog/lsu_config_regs.sv
// config and completion counters
`timescale 1ns/10ps
`include "lsu_defs.svh"

module lsu_config_regs (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  logic                      cfg_write,
    input  logic [`CFG_ADDR_BITS-1:0] cfg_addr,
    input  logic [31:0]               cfg_wdata,
    output logic [31:0]               cfg_rdata,
    input  logic                      result_valid,
    input  logic                      result_is_store,
    output logic [`WAIT_BITS-1:0]     wait_states
);

    logic [31:0] load_count;
    logic [31:0] store_count;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wait_states <= '0;
            load_count  <= 32'h0;
            store_count <= 32'h0;
        end else begin
            if (cfg_write && cfg_addr == `CFG_WAIT) begin
                wait_states <= cfg_wdata[`WAIT_BITS-1:0];
            end
            if (result_valid) begin
                if (result_is_store) begin
                    store_count <= store_count + 1'b1;
                end else begin
                    load_count <= load_count + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            `CFG_WAIT:   cfg_rdata = {{(32 - `WAIT_BITS){1'b0}}, wait_states};
            `CFG_LOADS:  cfg_rdata = load_count;
            `CFG_STORES: cfg_rdata = store_count;
            default:     cfg_rdata = 32'h0; // unmapped
        endcase
    end

endmodule

// File: verilog/data_ram.sv
// data RAM with wait states
`timescale 1ns/10ps
`include "lsu_defs.svh"

module data_ram (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  ram_en,
    input  logic                  ram_we,
    input  logic [`RAM_BITS-1:0]  ram_addr,
    input  logic [3:0]            ram_be,
    input  logic [31:0]           ram_wdata,
    output logic [31:0]           ram_rdata,
    output logic                  ram_ready,
    input  logic [`WAIT_BITS-1:0] wait_states
);

    logic [31:0]           mem [`RAM_WORDS];
    logic                  busy;
    logic [`WAIT_BITS-1:0] wait_cnt;

    // ready comes wait_states+1 cycles after the enable
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy      <= 1'b0;
            wait_cnt  <= '0;
            ram_ready <= 1'b0;
        end else begin
            ram_ready <= 1'b0;
            if (ram_en) begin
                if (wait_states == '0) begin
                    ram_ready <= 1'b1;
                end else begin
                    busy     <= 1'b1;
                    wait_cnt <= wait_states - 1'b1;
                end
            end else if (busy) begin
                if (wait_cnt == '0) begin
                    ram_ready <= 1'b1;
                    busy      <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end
        end
    end

    // array access at the enable, data held until ready
    always_ff @(posedge clk_in) begin
        if (ram_en) begin
            if (ram_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (ram_be[b]) begin
                        mem[ram_addr][8*b +: 8] <= ram_wdata[8*b +: 8];
                    end
                end
            end
            ram_rdata <= mem[ram_addr];
        end
    end

endmodule

// File: verilog/mem_access_port.sv
// memory access port
`timescale 1ns/10ps
`include "lsu_defs.svh"

module mem_access_port (
    input  logic                 clk_in,
    input  logic                 rst_in,
    // four-phase slave side
    input  logic                 mem_req,
    input  lsu_pkg::mem_op_e     mem_op,
    input  lsu_pkg::mem_width_e  mem_width,
    input  logic [31:0]          mem_addr,
    input  logic [31:0]          mem_wdata,
    output logic                 mem_ack,
    output logic [31:0]          mem_rdata,
    // word RAM
    output logic                 ram_en,
    output logic                 ram_we,
    output logic [`RAM_BITS-1:0] ram_addr,
    output logic [3:0]           ram_be,
    output logic [31:0]          ram_wdata,
    input  logic [31:0]          ram_rdata,
    input  logic                 ram_ready
);

    localparam logic [1:0] P_IDLE = 2'd0;
    localparam logic [1:0] P_WAIT = 2'd1; // RAM access running
    localparam logic [1:0] P_ACK  = 2'd2; // ack up until req falls

    logic [1:0]  state;
    logic [4:0]  lane_shift;
    logic [3:0]  store_be;
    logic [31:0] lane_data;
    logic [31:0] load_ext;

    // request fields stay stable for the whole handshake
    assign lane_shift = {mem_addr[1:0], 3'b000};
    assign lane_data  = ram_rdata >> lane_shift;

    always_comb begin
        case (mem_width)
            lsu_pkg::MW_BYTE,
            lsu_pkg::MW_BYTE_U: store_be = 4'b0001 << mem_addr[1:0];
            lsu_pkg::MW_HALF,
            lsu_pkg::MW_HALF_U: store_be = 4'b0011 << {mem_addr[1], 1'b0};
            default:            store_be = 4'b1111;
        endcase
    end

    // lane select then extend
    always_comb begin
        case (mem_width)
            lsu_pkg::MW_BYTE:   load_ext = {{24{lane_data[7]}}, lane_data[7:0]};
            lsu_pkg::MW_BYTE_U: load_ext = {24'h0, lane_data[7:0]};
            lsu_pkg::MW_HALF:   load_ext = {{16{lane_data[15]}}, lane_data[15:0]};
            lsu_pkg::MW_HALF_U: load_ext = {16'h0, lane_data[15:0]};
            default:            load_ext = ram_rdata;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state   <= P_IDLE;
            mem_ack <= 1'b0;
            ram_en  <= 1'b0;
        end else begin
            ram_en <= 1'b0; // single-cycle pulse
            case (state)
                P_IDLE: begin
                    if (mem_req) begin
                        ram_en <= 1'b1;
                        state  <= P_WAIT;
                    end
                end
                P_WAIT: begin
                    if (ram_ready) begin
                        mem_ack <= 1'b1;
                        state   <= P_ACK;
                    end
                end
                P_ACK: begin
                    if (!mem_req) begin
                        mem_ack <= 1'b0;
                        state   <= P_IDLE;
                    end
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == P_IDLE && mem_req) begin
            ram_we    <= (mem_op == lsu_pkg::MEM_STORE);
            ram_addr  <= mem_addr[`RAM_BITS+1:2];
            ram_be    <= store_be;
            ram_wdata <= mem_wdata << lane_shift; // move to byte lane
        end
        if (state == P_WAIT && ram_ready) begin
            mem_rdata <= load_ext;
        end
    end

endmodule

// File: verilog/load_store_queue.sv
// circular load/store queue
`timescale 1ns/10ps
`include "lsu_defs.svh"

module load_store_queue (
    input  logic                clk_in,
    input  logic                rst_in,
    // dispatch
    input  logic                issue_valid,
    input  lsu_pkg::mem_op_e    issue_op,
    input  lsu_pkg::mem_width_e issue_width,
    input  logic [31:0]         issue_imm,
    input  logic [31:0]         issue_base,
    input  logic [31:0]         issue_data,
    input  logic                issue_base_pending,
    input  logic                issue_data_pending,
    input  lsu_pkg::rob_tag_t   issue_base_tag,
    input  lsu_pkg::rob_tag_t   issue_data_tag,
    input  lsu_pkg::rob_tag_t   issue_dest_tag,
    output logic                full,
    // common data bus
    input  logic                cdb_valid,
    input  lsu_pkg::rob_tag_t   cdb_tag,
    input  logic [31:0]         cdb_value,
    // reorder buffer
    input  logic                commit_valid,
    input  lsu_pkg::rob_tag_t   commit_tag,
    input  logic                flush,
    // memory port, four-phase requester
    output logic                mem_req,
    output lsu_pkg::mem_op_e    mem_op,
    output lsu_pkg::mem_width_e mem_width,
    output logic [31:0]         mem_addr,
    output logic [31:0]         mem_wdata,
    input  logic                mem_ack,
    input  logic [31:0]         mem_rdata,
    // completion
    output logic                result_valid,
    output logic                result_is_store,
    output lsu_pkg::rob_tag_t   result_tag,
    output logic [31:0]         result_value
);

    localparam logic [1:0] HS_IDLE = 2'd0;
    localparam logic [1:0] HS_REQ  = 2'd1; // req up, waiting for ack
    localparam logic [1:0] HS_DROP = 2'd2; // req down, waiting for ack to fall

    // per-entry storage
    lsu_pkg::mem_op_e    e_op        [`LSQ_DEPTH];
    lsu_pkg::mem_width_e e_width     [`LSQ_DEPTH];
    logic [31:0]         e_imm       [`LSQ_DEPTH];
    logic [31:0]         e_base      [`LSQ_DEPTH];
    logic [31:0]         e_data      [`LSQ_DEPTH];
    logic                e_base_pend [`LSQ_DEPTH];
    logic                e_data_pend [`LSQ_DEPTH];
    lsu_pkg::rob_tag_t   e_base_tag  [`LSQ_DEPTH];
    lsu_pkg::rob_tag_t   e_data_tag  [`LSQ_DEPTH];
    lsu_pkg::rob_tag_t   e_dest_tag  [`LSQ_DEPTH];

    logic [`LSQ_BITS-1:0] head;
    logic [`LSQ_BITS-1:0] tail;
    logic [`LSQ_BITS-1:0] count;
    logic                 empty;
    logic [1:0]           hs_state;
    logic                 inflight_load;  // cleared by flush to drop the result
    lsu_pkg::rob_tag_t    inflight_tag;

    logic issue_we;
    logic head_is_store;
    logic head_ready;
    logic port_free;
    logic can_start;
    logic store_done;
    logic load_done;
    logic load_wake;

    // operand matches a broadcast this cycle
    function automatic logic tag_match(input lsu_pkg::rob_tag_t tag);
        tag_match = (cdb_valid && cdb_tag == tag) || (load_wake && result_tag == tag);
    endfunction

    function automatic logic [31:0] wake_value(input lsu_pkg::rob_tag_t tag);
        wake_value = (cdb_valid && cdb_tag == tag) ? cdb_value : result_value;
    endfunction

    assign count = tail - head;
    assign empty = (head == tail);
    assign full  = (count == `LSQ_DEPTH - 1);

    assign issue_we  = issue_valid && !full && !flush;
    assign load_wake = result_valid && !result_is_store;

    assign head_is_store = (e_op[head] == lsu_pkg::MEM_STORE);
    // stores wait for the rob, loads only for operands
    assign head_ready = !empty && !e_base_pend[head] && !e_data_pend[head] &&
                        (!head_is_store || (commit_valid && commit_tag == e_dest_tag[head]));
    assign port_free  = (hs_state == HS_IDLE) || (hs_state == HS_DROP && !mem_ack);
    assign can_start  = head_ready && port_free && !flush;

    assign store_done = can_start && head_is_store;
    assign load_done  = (hs_state == HS_REQ) && mem_ack && inflight_load && !flush;

    // pointers and handshake
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            head          <= '0;
            tail          <= '0;
            hs_state      <= HS_IDLE;
            mem_req       <= 1'b0;
            inflight_load <= 1'b0;
            result_valid  <= 1'b0;
        end else begin
            result_valid <= store_done || load_done;

            case (hs_state)
                HS_REQ: begin
                    if (mem_ack) begin
                        mem_req  <= 1'b0;
                        hs_state <= HS_DROP;
                    end
                end
                HS_DROP: begin
                    if (!mem_ack) begin
                        hs_state <= HS_IDLE;
                    end
                end
                default: hs_state <= HS_IDLE;
            endcase

            if (can_start) begin
                mem_req       <= 1'b1;
                hs_state      <= HS_REQ;
                inflight_load <= !head_is_store;
                head          <= head + 1'b1;
            end

            if (flush) begin
                head          <= '0;
                tail          <= '0;
                inflight_load <= 1'b0; // open access finishes silently
            end else if (issue_we) begin
                tail <= tail + 1'b1;
            end
        end
    end

    // entry payload, wakeup and access fields
    always_ff @(posedge clk_in) begin
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            if (e_base_pend[i] && tag_match(e_base_tag[i])) begin
                e_base[i]      <= wake_value(e_base_tag[i]);
                e_base_pend[i] <= 1'b0;
            end
            if (e_data_pend[i] && tag_match(e_data_tag[i])) begin
                e_data[i]      <= wake_value(e_data_tag[i]);
                e_data_pend[i] <= 1'b0;
            end
        end

        if (issue_we) begin
            e_op[tail]       <= issue_op;
            e_width[tail]    <= issue_width;
            e_imm[tail]      <= issue_imm;
            e_base_tag[tail] <= issue_base_tag;
            e_data_tag[tail] <= issue_data_tag;
            e_dest_tag[tail] <= issue_dest_tag;
            // catch a broadcast landing in the issue cycle
            if (issue_base_pending && tag_match(issue_base_tag)) begin
                e_base[tail]      <= wake_value(issue_base_tag);
                e_base_pend[tail] <= 1'b0;
            end else begin
                e_base[tail]      <= issue_base;
                e_base_pend[tail] <= issue_base_pending;
            end
            if (issue_data_pending && tag_match(issue_data_tag)) begin
                e_data[tail]      <= wake_value(issue_data_tag);
                e_data_pend[tail] <= 1'b0;
            end else begin
                e_data[tail]      <= issue_data;
                e_data_pend[tail] <= issue_data_pending;
            end
        end

        if (can_start) begin
            mem_op       <= e_op[head];
            mem_width    <= e_width[head];
            mem_addr     <= e_base[head] + e_imm[head];
            mem_wdata    <= e_data[head];
            inflight_tag <= e_dest_tag[head];
        end

        if (store_done) begin
            result_is_store <= 1'b1;        // commit ack, no data
            result_tag      <= e_dest_tag[head];
            result_value    <= 32'h0;
        end else if (load_done) begin
            result_is_store <= 1'b0;
            result_tag      <= inflight_tag;
            result_value    <= mem_rdata;
        end
    end

endmodule

// File: verilog/lsu_pkg.sv
// load/store unit types
`include "lsu_defs.svh"

package lsu_pkg;

    // direction of a memory access
    typedef enum logic {
        MEM_LOAD  = 1'b0,
        MEM_STORE = 1'b1
    } mem_op_e;

    // funct3 coding of lb/lh/lw/lbu/lhu and sb/sh/sw
    typedef enum logic [2:0] {
        MW_BYTE   = 3'b000,
        MW_HALF   = 3'b001,
        MW_WORD   = 3'b010,
        MW_BYTE_U = 3'b100,
        MW_HALF_U = 3'b101
    } mem_width_e;

    typedef logic [`ROB_BITS-1:0] rob_tag_t;

endpackage

// File: verilog/lsu_defs.svh
// load/store unit sizes
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// queue geometry, one slot always kept spare
`define LSQ_DEPTH 8
`define LSQ_BITS  3

`define ROB_BITS 4

// data RAM in 32-bit words
`define RAM_WORDS 256
`define RAM_BITS  8

// config port
`define WAIT_BITS     8
`define CFG_ADDR_BITS 2
`define CFG_WAIT      2'd0
`define CFG_LOADS     2'd1
`define CFG_STORES    2'd2

`endif
